// File: common/mem_pkg.sv
package mem_pkg;

    // SRAM pin widths
    localparam int SRAM_ADDR_WIDTH = 20; // Half-word address
    localparam int SRAM_DATA_WIDTH = 16;

    // Wishbone side, fixed at two SRAM halves per word
    localparam int WB_DATA_WIDTH = 32;
    localparam int WB_SEL_WIDTH  = WB_DATA_WIDTH / 8;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_LO_SETUP = 3'd1,
        ST_LO_WAIT  = 3'd2,
        ST_HI_SETUP = 3'd3,
        ST_HI_WAIT  = 3'd4,
        ST_ACK      = 3'd5
    } sram_state_e;

endpackage

// File: common/sram_if.sv
`timescale 1ns/1ps

interface sram_if ();

    logic                                  ce_n;
    logic                                  oe_n;
    logic                                  we_n;
    logic                                  ub_n;
    logic                                  lb_n;
    logic [mem_pkg::SRAM_ADDR_WIDTH-1:0]   addr;
    logic [mem_pkg::SRAM_DATA_WIDTH-1:0]   wdata;
    logic [mem_pkg::SRAM_DATA_WIDTH-1:0]   rdata;  // Half-word sampled on the previous clock

    modport ctrl (
        output ce_n, oe_n, we_n, ub_n, lb_n, addr, wdata,
        input  rdata
    );

    modport phy (
        input  ce_n, oe_n, we_n, ub_n, lb_n, addr, wdata,
        output rdata
    );

endinterface

// File: common/wb_if.sv
`timescale 1ns/1ps

interface wb_if #(
    parameter OPTN_WB_ADDR_WIDTH = 32
)();

    logic                                cyc;
    logic                                stb;
    logic                                we;
    logic [mem_pkg::WB_SEL_WIDTH-1:0]    sel;
    logic [OPTN_WB_ADDR_WIDTH-1:0]       addr;   // Byte address
    logic [mem_pkg::WB_DATA_WIDTH-1:0]   wdata;
    logic                                ack;
    logic [mem_pkg::WB_DATA_WIDTH-1:0]   rdata;

    modport master (
        output cyc, stb, we, sel, addr, wdata,
        input  ack, rdata
    );

    modport slave (
        input  cyc, stb, we, sel, addr, wdata,
        output ack, rdata
    );

endinterface

// File: design/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys #(
    parameter OPTN_WB_ADDR_WIDTH   = 32,
    parameter OPTN_REQ_QUEUE_DEPTH = 4,
    parameter OPTN_SRAM_BASE_ADDR  = 0
)(
    input  logic                                clk,
    input  logic                                i_reset,

    // Request and response strobes
    input  logic                                i_req_valid,
    input  mem_pkg::mem_op_e                    i_req_op,
    input  logic [OPTN_WB_ADDR_WIDTH-1:0]       i_req_addr,
    input  logic [mem_pkg::WB_DATA_WIDTH-1:0]   i_req_wdata,
    input  logic [mem_pkg::WB_SEL_WIDTH-1:0]    i_req_sel,
    output logic                                o_rsp_valid,
    output logic [mem_pkg::WB_DATA_WIDTH-1:0]   o_rsp_data,
    output logic                                o_overflow,

    // SRAM pins
    output logic [mem_pkg::SRAM_ADDR_WIDTH-1:0] o_sram_addr,
    input  logic [mem_pkg::SRAM_DATA_WIDTH-1:0] i_sram_dq,
    output logic [mem_pkg::SRAM_DATA_WIDTH-1:0] o_sram_dq,
    output logic                                o_sram_ce_n,
    output logic                                o_sram_oe_n,
    output logic                                o_sram_we_n,
    output logic                                o_sram_ub_n,
    output logic                                o_sram_lb_n
);

    wb_if #(
        .OPTN_WB_ADDR_WIDTH(OPTN_WB_ADDR_WIDTH)
    ) wb ();

    sram_if sram ();

    wb_req_master #(
        .OPTN_WB_ADDR_WIDTH(OPTN_WB_ADDR_WIDTH),
        .OPTN_REQ_QUEUE_DEPTH(OPTN_REQ_QUEUE_DEPTH)
    ) wb_req_master_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_req_valid(i_req_valid),
        .i_req_op(i_req_op),
        .i_req_addr(i_req_addr),
        .i_req_wdata(i_req_wdata),
        .i_req_sel(i_req_sel),
        .o_rsp_valid(o_rsp_valid),
        .o_rsp_data(o_rsp_data),
        .o_overflow(o_overflow),
        .wb(wb.master)
    );

    sram_wb #(
        .OPTN_WB_ADDR_WIDTH(OPTN_WB_ADDR_WIDTH),
        .OPTN_SRAM_BASE_ADDR(OPTN_SRAM_BASE_ADDR)
    ) sram_wb_inst (
        .clk(clk),
        .i_reset(i_reset),
        .wb(wb.slave),
        .sram(sram.ctrl)
    );

    sram_phy sram_phy_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_sram_dq(i_sram_dq),
        .o_sram_addr(o_sram_addr),
        .o_sram_dq(o_sram_dq),
        .o_sram_ce_n(o_sram_ce_n),
        .o_sram_oe_n(o_sram_oe_n),
        .o_sram_we_n(o_sram_we_n),
        .o_sram_ub_n(o_sram_ub_n),
        .o_sram_lb_n(o_sram_lb_n),
        .sram(sram.phy)
    );

endmodule

// File: design/wb_req_master.sv
`timescale 1ns/1ps

module wb_req_master #(
    parameter OPTN_WB_ADDR_WIDTH   = 32,
    parameter OPTN_REQ_QUEUE_DEPTH = 4
)(
    input  logic                                clk,
    input  logic                                i_reset,

    input  logic                                i_req_valid,
    input  mem_pkg::mem_op_e                    i_req_op,
    input  logic [OPTN_WB_ADDR_WIDTH-1:0]       i_req_addr,
    input  logic [mem_pkg::WB_DATA_WIDTH-1:0]   i_req_wdata,
    input  logic [mem_pkg::WB_SEL_WIDTH-1:0]    i_req_sel,

    output logic                                o_rsp_valid,
    output logic [mem_pkg::WB_DATA_WIDTH-1:0]   o_rsp_data,
    output logic                                o_overflow,

    wb_if.master                                wb
);

    localparam PTR_WIDTH = (OPTN_REQ_QUEUE_DEPTH > 1) ? $clog2(OPTN_REQ_QUEUE_DEPTH) : 1;
    localparam CNT_WIDTH = $clog2(OPTN_REQ_QUEUE_DEPTH + 1);

    mem_pkg::mem_op_e                    q_op    [OPTN_REQ_QUEUE_DEPTH];
    logic [OPTN_WB_ADDR_WIDTH-1:0]       q_addr  [OPTN_REQ_QUEUE_DEPTH];
    logic [mem_pkg::WB_DATA_WIDTH-1:0]   q_wdata [OPTN_REQ_QUEUE_DEPTH];
    logic [mem_pkg::WB_SEL_WIDTH-1:0]    q_sel   [OPTN_REQ_QUEUE_DEPTH];

    logic [PTR_WIDTH-1:0] head;
    logic [PTR_WIDTH-1:0] tail;
    logic [CNT_WIDTH-1:0] count;
    logic                 full;
    logic                 push;
    logic                 pop;
    logic                 rd_ack;

    function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
        logic [PTR_WIDTH-1:0] nxt;
        if (ptr == PTR_WIDTH'(OPTN_REQ_QUEUE_DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign full   = (count == CNT_WIDTH'(OPTN_REQ_QUEUE_DEPTH));
    assign push   = i_req_valid && !full;
    assign pop    = !wb.cyc && (count != '0);       // Only one bus cycle in flight
    assign rd_ack = wb.cyc && wb.ack && !wb.we;

    always_ff @(posedge clk) begin
        if (push) begin
            q_op[tail]    <= i_req_op;
            q_addr[tail]  <= i_req_addr;
            q_wdata[tail] <= i_req_wdata;
            q_sel[tail]   <= i_req_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) tail <= ptr_inc(tail);
            if (pop) head <= ptr_inc(head);

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wb.cyc <= 1'b0;
            wb.stb <= 1'b0;
        end else if (pop) begin
            wb.cyc <= 1'b1;
            wb.stb <= 1'b1;
        end else if (wb.ack) begin
            wb.cyc <= 1'b0;                          // Drop in the clock after ack
            wb.stb <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            wb.we    <= (q_op[head] == mem_pkg::MEM_WRITE);
            wb.addr  <= q_addr[head];
            wb.wdata <= q_wdata[head];
            wb.sel   <= q_sel[head];
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_rsp_valid <= 1'b0;
            o_overflow  <= 1'b0;
        end else begin
            o_rsp_valid <= rd_ack;
            if (i_req_valid && full) o_overflow <= 1'b1; // Sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ack) o_rsp_data <= wb.rdata;
    end

    stb_held_until_ack: assert property (
        @(posedge clk) disable iff (i_reset)
        wb.stb && !wb.ack |=> wb.stb
    ) else $error("wishbone stb fell before ack");

endmodule

// File: sim.f
common/mem_pkg.sv
common/wb_if.sv
common/sram_if.sv
design/wb_req_master.sv
sram_ctrl/sram_wb.sv
sram_ctrl/sram_phy.sv
design/mem_subsys.sv
verif/tb_clock.sv
verif/sram_model.sv
verif/tb_mem_subsys.sv

// File: sram_ctrl/sram_phy.sv
`timescale 1ns/1ps

module sram_phy (
    input  logic                                clk,
    input  logic                                i_reset,

    input  logic [mem_pkg::SRAM_DATA_WIDTH-1:0] i_sram_dq,
    output logic [mem_pkg::SRAM_ADDR_WIDTH-1:0] o_sram_addr,
    output logic [mem_pkg::SRAM_DATA_WIDTH-1:0] o_sram_dq,
    output logic                                o_sram_ce_n,
    output logic                                o_sram_oe_n,
    output logic                                o_sram_we_n,
    output logic                                o_sram_ub_n,
    output logic                                o_sram_lb_n,

    sram_if.phy                                 sram
);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_sram_ce_n <= 1'b1;
            o_sram_oe_n <= 1'b1;
            o_sram_we_n <= 1'b1;
            o_sram_ub_n <= 1'b1;
            o_sram_lb_n <= 1'b1;
        end else begin
            o_sram_ce_n <= sram.ce_n;
            o_sram_oe_n <= sram.oe_n;
            o_sram_we_n <= sram.we_n;
            o_sram_ub_n <= sram.ub_n;
            o_sram_lb_n <= sram.lb_n;
        end
    end

    always_ff @(posedge clk) begin
        o_sram_addr <= sram.addr;
        o_sram_dq   <= sram.wdata;  // Only meaningful while we_n is low
        sram.rdata  <= i_sram_dq;
    end

    no_oe_we_overlap: assert property (
        @(posedge clk) disable iff (i_reset)
        !(!o_sram_oe_n && !o_sram_we_n)
    ) else $error("sram oe_n and we_n both low at the pins");

endmodule

// File: sram_ctrl/sram_wb.sv
`timescale 1ns/1ps

module sram_wb #(
    parameter OPTN_WB_ADDR_WIDTH  = 32,
    parameter OPTN_SRAM_BASE_ADDR = 0
)(
    input  logic    clk,
    input  logic    i_reset,

    wb_if.slave     wb,
    sram_if.ctrl    sram
);

    localparam WIN_BITS = mem_pkg::SRAM_ADDR_WIDTH + 1; // Byte address bits inside the window
    localparam logic [OPTN_WB_ADDR_WIDTH-1:0] BASE_ADDR =
        OPTN_WB_ADDR_WIDTH'(OPTN_SRAM_BASE_ADDR);

    mem_pkg::sram_state_e                   state;
    mem_pkg::sram_state_e                   state_next;

    logic [OPTN_WB_ADDR_WIDTH-1:0]          offset;
    logic [mem_pkg::SRAM_ADDR_WIDTH-2:0]    word_off;
    logic                                   in_window;
    logic                                   req;
    logic                                   lo_used;
    logic                                   hi_used;
    logic                                   hi_phase;
    logic                                   wait_phase;
    logic                                   active;
    logic                                   hit;
    logic [mem_pkg::SRAM_DATA_WIDTH-1:0]    rd_lo;

    assign offset    = wb.addr - BASE_ADDR;
    assign in_window = (wb.addr >= BASE_ADDR) &&
                       (offset[OPTN_WB_ADDR_WIDTH-1:WIN_BITS] == '0);
    assign word_off  = offset[WIN_BITS-1:2];
    assign req       = wb.cyc && wb.stb;

    // Reads always use both halves, writes only the halves with a byte selected
    assign lo_used = !wb.we || (wb.sel[1:0] != '0);
    assign hi_used = !wb.we || (wb.sel[3:2] != '0);

    assign hi_phase   = (state == mem_pkg::ST_HI_SETUP) || (state == mem_pkg::ST_HI_WAIT);
    assign wait_phase = (state == mem_pkg::ST_LO_WAIT) || (state == mem_pkg::ST_HI_WAIT);
    assign active     = hi_phase || wait_phase || (state == mem_pkg::ST_LO_SETUP);

    always_comb begin
        state_next = state;

        case (state)
            mem_pkg::ST_IDLE: begin
                if (req) begin
                    if (!in_window) state_next = mem_pkg::ST_ACK;
                    else if (lo_used) state_next = mem_pkg::ST_LO_SETUP;
                    else if (hi_used) state_next = mem_pkg::ST_HI_SETUP;
                    else state_next = mem_pkg::ST_ACK;
                end
            end
            mem_pkg::ST_LO_SETUP: state_next = mem_pkg::ST_LO_WAIT;
            mem_pkg::ST_LO_WAIT:  state_next = hi_used ? mem_pkg::ST_HI_SETUP : mem_pkg::ST_ACK;
            mem_pkg::ST_HI_SETUP: state_next = mem_pkg::ST_HI_WAIT;
            mem_pkg::ST_HI_WAIT:  state_next = mem_pkg::ST_ACK;
            default:              state_next = mem_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) state <= mem_pkg::ST_IDLE;
        else state <= state_next;
    end

    // Write enable only pulses in WAIT so the address is settled around it
    assign sram.ce_n  = !active;
    assign sram.oe_n  = !(active && !wb.we);
    assign sram.we_n  = !(wait_phase && wb.we);
    assign sram.lb_n  = !active || (wb.we && !(hi_phase ? wb.sel[2] : wb.sel[0]));
    assign sram.ub_n  = !active || (wb.we && !(hi_phase ? wb.sel[3] : wb.sel[1]));
    assign sram.addr  = {word_off, hi_phase};
    assign sram.wdata = hi_phase ? wb.wdata[31:16] : wb.wdata[15:0];

    always_ff @(posedge clk) begin
        if ((state == mem_pkg::ST_IDLE) && req) hit <= in_window;
        if (state == mem_pkg::ST_HI_SETUP) rd_lo <= sram.rdata; // Low half arrives after LO_WAIT
    end

    // High half is live from the pin stage during ACK
    assign wb.ack   = (state == mem_pkg::ST_ACK);
    assign wb.rdata = hit ? {sram.rdata, rd_lo} : '0;

    ack_one_cycle: assert property (
        @(posedge clk) disable iff (i_reset)
        wb.ack |=> !wb.ack
    ) else $error("wishbone ack held longer than one cycle");

    idle_ce_high: assert property (
        @(posedge clk) disable iff (i_reset)
        (state == mem_pkg::ST_IDLE) && !(req && in_window) |=> sram.ce_n
    ) else $error("sram ce_n low after idle without a window access");

endmodule

// File: verif/sram_model.sv
`timescale 1ns/1ps

module sram_model (
    input  logic [mem_pkg::SRAM_ADDR_WIDTH-1:0] i_addr,
    input  logic [mem_pkg::SRAM_DATA_WIDTH-1:0] i_dq,
    input  logic                                i_ce_n,
    input  logic                                i_oe_n,
    input  logic                                i_we_n,
    input  logic                                i_ub_n,
    input  logic                                i_lb_n,
    output logic [mem_pkg::SRAM_DATA_WIDTH-1:0] o_dq
);

    localparam int DEPTH = 1 << mem_pkg::SRAM_ADDR_WIDTH;

    logic [mem_pkg::SRAM_DATA_WIDTH-1:0] mem [DEPTH];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = i[15:0] ^ {i[19:16], i[19:8]}; // Power-up pattern over the whole address
        end
    end

    assign o_dq = (!i_ce_n && !i_oe_n) ? mem[i_addr] : 'x;

    // Level-sensitive write, as on a real asynchronous part
    always @(i_ce_n or i_we_n or i_lb_n or i_ub_n or i_addr or i_dq) begin
        if (!i_ce_n && !i_we_n) begin
            if (!i_lb_n) mem[i_addr][7:0] = i_dq[7:0];
            if (!i_ub_n) mem[i_addr][15:8] = i_dq[15:8];
        end
    end

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 10.0
)(
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

endmodule

// File: verif/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int CLK_PERIOD = 10;
    localparam int QDEPTH     = 4;
    localparam int N_REQ      = 25;
    localparam int TIMEOUT_NS = (N_REQ * 40 + 200) * CLK_PERIOD;

    logic                                clk;
    logic                                i_reset;
    logic                                i_req_valid;
    mem_pkg::mem_op_e                    i_req_op;
    logic [31:0]                         i_req_addr;
    logic [31:0]                         i_req_wdata;
    logic [3:0]                          i_req_sel;
    logic                                o_rsp_valid;
    logic [31:0]                         o_rsp_data;
    logic                                o_overflow;
    logic [mem_pkg::SRAM_ADDR_WIDTH-1:0] o_sram_addr;
    logic [mem_pkg::SRAM_DATA_WIDTH-1:0] i_sram_dq;
    logic [mem_pkg::SRAM_DATA_WIDTH-1:0] o_sram_dq;
    logic                                o_sram_ce_n;
    logic                                o_sram_oe_n;
    logic                                o_sram_we_n;
    logic                                o_sram_ub_n;
    logic                                o_sram_lb_n;

    logic [7:0]  ref_mem [int unsigned];   // Byte-lane reference keyed by byte address
    logic [31:0] exp_q [$];
    string       exp_name_q [$];
    logic [31:0] rng_state;
    logic        outwin_active;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) clock_gen (.o_clk(clk));

    mem_subsys #(
        .OPTN_WB_ADDR_WIDTH(32),
        .OPTN_REQ_QUEUE_DEPTH(QDEPTH),
        .OPTN_SRAM_BASE_ADDR(0)
    ) i_mem_subsys (
        .clk(clk), .i_reset(i_reset),
        .i_req_valid(i_req_valid), .i_req_op(i_req_op), .i_req_addr(i_req_addr),
        .i_req_wdata(i_req_wdata), .i_req_sel(i_req_sel),
        .o_rsp_valid(o_rsp_valid), .o_rsp_data(o_rsp_data), .o_overflow(o_overflow),
        .o_sram_addr(o_sram_addr), .i_sram_dq(i_sram_dq), .o_sram_dq(o_sram_dq),
        .o_sram_ce_n(o_sram_ce_n), .o_sram_oe_n(o_sram_oe_n), .o_sram_we_n(o_sram_we_n),
        .o_sram_ub_n(o_sram_ub_n), .o_sram_lb_n(o_sram_lb_n)
    );

    sram_model sram (
        .i_addr(o_sram_addr), .i_dq(o_sram_dq), .i_ce_n(o_sram_ce_n), .i_oe_n(o_sram_oe_n),
        .i_we_n(o_sram_we_n), .i_ub_n(o_sram_ub_n), .i_lb_n(o_sram_lb_n), .o_dq(i_sram_dq)
    );

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("error %s expected %h actual %h", name, exp, act);
        fail_plain("value mismatch");
    endtask

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] random_word_addr();
        return next_random() & 32'h001f_fffc; // Word aligned, inside the 2 MiB window
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        logic [31:0] w;
        for (int b = 0; b < 4; b++) begin
            w[b*8 +: 8] = ref_mem.exists(addr + b) ? ref_mem[addr + b] : 8'hxx;
        end
        return w;
    endfunction

    // Drives one strobe and records what the DUT should do with it
    task automatic send_req(input string name, input mem_pkg::mem_op_e op,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] sel, input bit track);
        @(negedge clk);
        i_req_valid = 1'b1;
        i_req_op    = op;
        i_req_addr  = addr;
        i_req_wdata = wdata;
        i_req_sel   = sel;
        if (op == mem_pkg::MEM_WRITE && track) begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) ref_mem[addr + b] = wdata[b*8 +: 8];
            end
        end else if (op == mem_pkg::MEM_READ) begin
            exp_q.push_back(addr < 32'h0020_0000 ? ref_word(addr) : 32'h0);
            exp_name_q.push_back(name);
        end
    endtask

    task automatic release_req();
        @(negedge clk);
        i_req_valid = 1'b0;
    endtask

    task automatic wait_responses();
        while (exp_q.size() != 0) @(posedge clk);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        i_reset = 1'b1;
        repeat (5) @(negedge clk);
        i_reset = 1'b0;
    endtask

    always @(posedge clk) begin
        logic [31:0] exp;
        string       name;
        if (!i_reset && o_rsp_valid) begin
            if (exp_q.size() == 0) fail_plain("read response arrived with none outstanding");
            exp  = exp_q.pop_front();
            name = exp_name_q.pop_front();
            assert (o_rsp_data === exp) else fail_value(name, exp, o_rsp_data);
        end
    end

    reset_state: assert property (@(posedge clk) $fell(i_reset) |->
        (o_sram_ce_n && o_sram_oe_n && o_sram_we_n && o_sram_ub_n && o_sram_lb_n &&
         !o_rsp_valid && !o_overflow))
        else fail_plain("outputs not at their idle levels after reset");

    outwin_no_ce: assert property (@(posedge clk) outwin_active |-> o_sram_ce_n)
        else fail_plain("sram ce_n went low for an access outside the window");

    overflow_sticky: assert property (@(posedge clk) disable iff (i_reset)
        o_overflow |=> o_overflow)
        else fail_plain("overflow flag cleared without reset");

    initial begin
        #(TIMEOUT_NS);
        fail_plain("watchdog timeout, the DUT stopped responding");
    end

    initial begin
        logic [31:0] a;
        logic [31:0] rd_addr [QDEPTH];
        rng_state     = 32'h117f;
        outwin_active = 1'b0;
        i_reset       = 1'b1;
        i_req_valid   = 1'b0;
        i_req_op      = mem_pkg::MEM_READ;
        i_req_addr    = '0;
        i_req_wdata   = '0;
        i_req_sel     = '0;
        repeat (5) @(negedge clk);
        i_reset = 1'b0;

        a = random_word_addr();
        send_req("full_write", mem_pkg::MEM_WRITE, a, next_random(), 4'hf, 1);
        send_req("full_read", mem_pkg::MEM_READ, a, '0, 4'hf, 1);
        release_req();
        wait_responses();

        a = random_word_addr();
        send_req("partial_base", mem_pkg::MEM_WRITE, a, next_random(), 4'hf, 1);
        send_req("partial_lo", mem_pkg::MEM_WRITE, a, next_random(), 4'b0001, 1);
        send_req("partial_hi", mem_pkg::MEM_WRITE, a, next_random(), 4'b1000, 1);
        send_req("partial_mid", mem_pkg::MEM_WRITE, a, next_random(), 4'b0110, 1);
        send_req("partial_read", mem_pkg::MEM_READ, a, '0, 4'hf, 1);
        release_req();
        wait_responses();

        for (int i = 0; i < QDEPTH; i++) begin
            rd_addr[i] = random_word_addr();
            send_req("burst_write", mem_pkg::MEM_WRITE, rd_addr[i], next_random(), 4'hf, 1);
            release_req();
        end
        // The read completes only after every queued write, so the queue is empty afterwards
        send_req("burst_drain", mem_pkg::MEM_READ, rd_addr[QDEPTH-1], '0, 4'hf, 1);
        release_req();
        wait_responses();
        for (int i = 0; i < QDEPTH; i++) begin
            send_req("burst_read", mem_pkg::MEM_READ, rd_addr[i], '0, 4'hf, 1);
        end
        release_req();
        wait_responses();

        outwin_active = 1'b1;
        send_req("outside_window", mem_pkg::MEM_READ, 32'h0020_0000 | random_word_addr(),
                 '0, 4'hf, 1);
        release_req();
        wait_responses();
        outwin_active = 1'b0;

        assert (o_overflow === 1'b0) else fail_value("overflow_clear", 32'h0, {31'h0, o_overflow});

        // Writes into untracked locations only, since some of them get dropped
        for (int i = 0; i < 2 * QDEPTH; i++) begin
            send_req("overflow", mem_pkg::MEM_WRITE, random_word_addr(), next_random(), 4'hf, 0);
        end
        release_req();
        assert (o_overflow === 1'b1) else fail_value("overflow_set", 32'h1, {31'h0, o_overflow});
        repeat (3) @(negedge clk);
        apply_reset();
        @(negedge clk);
        assert (o_overflow === 1'b0) else fail_value("overflow_reset", 32'h0, {31'h0, o_overflow});

        if (exp_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_plain("read responses still outstanding at the end");
        end
    end

endmodule
